// File: Makefile
# Verilator build and run for the multiply/divide cluster

TOP      ?= mdu_tb
RTL_TOP  ?= mdu_top
FLIST    ?= vlog.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
VFLAGS   ?= --binary --timing -Wno-fatal -j 0
LFLAGS   ?= --lint-only -Wall

PASS_MSG := ALL CHECKS PASSED
RTL_SRCS := $(shell grep '^rtl/' $(FLIST))

.PHONY: all build run lint clean

all: run

build:
	verilator $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	verilator $(LFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/mdu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_tb;
    import mdu_pkg::*;

    localparam int NUM_ROWS    = 26;
    localparam int CYCLE_LIMIT = NUM_ROWS * 40 + 200;
    localparam int NUM_IDS     = 1 << ROB_ID_W;

    // rows still in flight when the flush hits
    localparam int FLUSH_FIRST = 21;
    localparam int FLUSH_LAST  = 23;

    typedef struct packed {
        mdu_op_t    op;
        word_t      a;
        word_t      b;
        logic       pres_a;
        logic       pres_b;
        rob_id_t    rob;
        logic [3:0] dly_a;
        logic [3:0] dly_b;
    } row_t;

    // op, a, b, a present, b present, rob id, cdb delay a, cdb delay b
    row_t rows [NUM_ROWS] = '{
        '{OP_MUL,   32'h0000_0007, 32'hffff_fffd, 1'b1, 1'b1, 5'd0,  4'd0,  4'd0},
        '{OP_MULH,  32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b1, 5'd1,  4'd0,  4'd0},
        '{OP_MULHU, 32'hffff_ffff, 32'hffff_ffff, 1'b1, 1'b1, 5'd2,  4'd0,  4'd0},
        '{OP_MULH,  32'h1234_5678, 32'h9abc_def0, 1'b1, 1'b1, 5'd3,  4'd0,  4'd0},
        '{OP_MUL,   32'hdead_beef, 32'h0000_1001, 1'b1, 1'b1, 5'd4,  4'd0,  4'd0},
        '{OP_DIV,   32'hffff_ff9c, 32'h0000_0007, 1'b1, 1'b1, 5'd5,  4'd0,  4'd0},
        '{OP_DIVU,  32'hffff_fff0, 32'h0000_0003, 1'b1, 1'b1, 5'd6,  4'd0,  4'd0},
        '{OP_MOD,   32'hffff_ff9c, 32'h0000_0007, 1'b1, 1'b1, 5'd7,  4'd0,  4'd0},
        '{OP_MODU,  32'h0000_03e8, 32'h0000_0021, 1'b1, 1'b1, 5'd8,  4'd0,  4'd0},
        '{OP_DIV,   32'h0000_04d2, 32'h0000_0000, 1'b1, 1'b1, 5'd9,  4'd0,  4'd0},
        '{OP_MODU,  32'h0000_162e, 32'h0000_0000, 1'b1, 1'b1, 5'd10, 4'd0,  4'd0},
        '{OP_DIV,   32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b1, 5'd11, 4'd0,  4'd0},
        '{OP_MOD,   32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b1, 5'd12, 4'd0,  4'd0},
        '{OP_MUL,   32'h0000_1234, 32'h0000_0100, 1'b0, 1'b1, 5'd13, 4'd0,  4'd0},
        '{OP_DIV,   32'hffff_8000, 32'h0000_0031, 1'b0, 1'b0, 5'd14, 4'd3,  4'd5},
        '{OP_MULHU, 32'h8765_4321, 32'hfedc_ba98, 1'b1, 1'b0, 5'd15, 4'd0,  4'd0},
        '{OP_MODU,  32'h7fff_ffff, 32'h0001_0000, 1'b0, 1'b0, 5'd16, 4'd2,  4'd0},
        '{OP_MUL,   32'h0000_0005, 32'h0000_0006, 1'b0, 1'b1, 5'd17, 4'd10, 4'd0},
        '{OP_DIVU,  32'h0000_0064, 32'h0000_0009, 1'b1, 1'b1, 5'd18, 4'd0,  4'd0},
        '{OP_MULH,  32'hffff_fffe, 32'h7fff_ffff, 1'b1, 1'b1, 5'd19, 4'd0,  4'd0},
        '{OP_MOD,   32'h0000_0064, 32'hffff_fff9, 1'b1, 1'b1, 5'd20, 4'd0,  4'd0},
        '{OP_DIV,   32'h0000_1000, 32'h0000_0010, 1'b1, 1'b1, 5'd21, 4'd0,  4'd0},
        '{OP_DIVU,  32'h0000_2000, 32'h0000_0020, 1'b1, 1'b1, 5'd22, 4'd0,  4'd0},
        '{OP_MUL,   32'h0000_0003, 32'h0000_0004, 1'b0, 1'b1, 5'd23, 4'd15, 4'd0},
        '{OP_MULHU, 32'hc000_0000, 32'h0000_0004, 1'b1, 1'b1, 5'd24, 4'd0,  4'd0},
        '{OP_DIV,   32'h0000_0007, 32'hffff_fffe, 1'b1, 1'b1, 5'd25, 4'd0,  4'd0}
    };

    logic    clk;
    logic    rst_n_i;
    logic    flush_i;
    logic    disp_valid_i;
    logic    disp_ready_o;
    mdu_op_t disp_op_i;
    rob_id_t disp_rob_id_i;
    word_t   disp_src_a_i;
    word_t   disp_src_b_i;
    rob_id_t disp_tag_a_i;
    rob_id_t disp_tag_b_i;
    logic    disp_present_a_i;
    logic    disp_present_b_i;
    logic    cdb_valid_i;
    rob_id_t cdb_tag_i;
    word_t   cdb_data_i;
    logic    result_valid_o;
    logic    result_ready_i;
    word_t   result_data_o;
    rob_id_t result_rob_id_o;

    // scoreboard indexed by rob id
    word_t   exp_data    [NUM_IDS];
    logic    pending     [NUM_IDS];
    logic    is_div      [NUM_IDS];
    int      outstanding [NUM_IDS];
    rob_id_t mul_order   [$];
    rob_id_t div_order   [$];

    // cdb broadcasts still to be sent
    int      ev_due  [$];
    rob_id_t ev_tag  [$];
    word_t   ev_data [$];
    rob_id_t ev_rob  [$];

    int      live_cnt    = 0;
    int      retired_cnt = 0;
    int      cyc         = 0;
    int      wd_cnt      = 0;
    int      seed        = 32'h9451b07b;
    string   cur_test    = "reset";

    logic    held = 1'b0;
    rob_id_t held_rob;
    word_t   held_data;

    mdu_top i_mdu_top (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .disp_valid_i     (disp_valid_i),
        .disp_ready_o     (disp_ready_o),
        .disp_op_i        (disp_op_i),
        .disp_rob_id_i    (disp_rob_id_i),
        .disp_src_a_i     (disp_src_a_i),
        .disp_src_b_i     (disp_src_b_i),
        .disp_tag_a_i     (disp_tag_a_i),
        .disp_tag_b_i     (disp_tag_b_i),
        .disp_present_a_i (disp_present_a_i),
        .disp_present_b_i (disp_present_b_i),
        .cdb_valid_i      (cdb_valid_i),
        .cdb_tag_i        (cdb_tag_i),
        .cdb_data_i       (cdb_data_i),
        .result_valid_o   (result_valid_o),
        .result_ready_i   (result_ready_i),
        .result_data_o    (result_data_o),
        .result_rob_id_o  (result_rob_id_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        wd_cnt++;
        if (wd_cnt > CYCLE_LIMIT) begin
            $display("timeout: no completion within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------
    // checks
    // ----------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_rob_id(input string name, input rob_id_t exp, input rob_id_t act);
        if (pending[act] !== 1'b1) begin
            report_failure($sformatf("%s: rob id %0d was never expected or already retired",
                                     name, act));
        end else if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    // expected result straight from the op definitions
    function automatic word_t model_result(input mdu_op_t op, input word_t a, input word_t b);
        longint          s_prod;
        longint unsigned u_prod;
        s_prod = longint'($signed(a)) * longint'($signed(b));
        u_prod = {32'h0, a} * {32'h0, b};
        if (op[OP_W-1] && (b == '0)) begin
            return ((op == OP_DIV) || (op == OP_DIVU)) ? '1 : a;
        end
        if (((op == OP_DIV) || (op == OP_MOD)) && (a == 32'h8000_0000) && (b == '1)) begin
            return (op == OP_DIV) ? a : '0;
        end
        case (op)
            OP_MUL:   return s_prod[31:0];
            OP_MULH:  return s_prod[63:32];
            OP_MULHU: return u_prod[63:32];
            OP_DIV:   return $signed(a) / $signed(b);
            OP_DIVU:  return a / b;
            OP_MOD:   return $signed(a) % $signed(b);
            default:  return a % b;
        endcase
    endfunction

    // ----------------------------
    // stimulus
    // ----------------------------
    task automatic next_cycle();
        @(posedge clk);
        #2;
        cyc++;
        disp_valid_i   = 1'b0;
        cdb_valid_i    = 1'b0;
        flush_i        = 1'b0;
        result_ready_i = (($random(seed) % 4) != 0);
    endtask

    task automatic schedule_cdb(input int due, input rob_id_t tag, input word_t data,
                                input rob_id_t rob);
        ev_due.push_back(due);
        ev_tag.push_back(tag);
        ev_data.push_back(data);
        ev_rob.push_back(rob);
    endtask

    // one broadcast per cycle with the oldest due event first
    task automatic drive_cdb();
        int k;
        k = 0;
        while ((k < ev_due.size()) && (ev_due[k] > cyc)) begin
            k++;
        end
        if (k < ev_due.size()) begin
            cdb_valid_i = 1'b1;
            cdb_tag_i   = ev_tag[k];
            cdb_data_i  = ev_data[k];
            outstanding[ev_rob[k]]--;
            ev_due.delete(k);
            ev_tag.delete(k);
            ev_data.delete(k);
            ev_rob.delete(k);
        end
    endtask

    task automatic idle_cycle();
        next_cycle();
        drive_cdb();
    endtask

    task automatic drive_row(input int i);
        row_t    r;
        rob_id_t tag_b;
        r     = rows[i];
        tag_b = r.rob + 5'd16;
        disp_valid_i     = 1'b1;
        disp_op_i        = r.op;
        disp_rob_id_i    = r.rob;
        // a missing operand carries junk until the cdb delivers it
        disp_src_a_i     = r.pres_a ? r.a : ~r.a;
        disp_src_b_i     = r.pres_b ? r.b : ~r.b;
        disp_tag_a_i     = r.rob;
        disp_tag_b_i     = tag_b;
        disp_present_a_i = r.pres_a;
        disp_present_b_i = r.pres_b;
        if (!r.pres_a) begin
            schedule_cdb(cyc + int'(r.dly_a), r.rob, r.a, r.rob);
        end
        if (!r.pres_b) begin
            schedule_cdb(cyc + int'(r.dly_b), tag_b, r.b, r.rob);
        end
        exp_data[r.rob]    = model_result(r.op, r.a, r.b);
        pending[r.rob]     = 1'b1;
        is_div[r.rob]      = r.op[OP_W-1];
        outstanding[r.rob] = int'(!r.pres_a) + int'(!r.pres_b);
        if (r.op[OP_W-1]) begin
            div_order.push_back(r.rob);
        end else begin
            mul_order.push_back(r.rob);
        end
        live_cnt++;
    endtask

    task automatic apply_rows(input int first, input int last);
        int i;
        i = first;
        while (i <= last) begin
            next_cycle();
            if (disp_ready_o) begin
                drive_row(i);
                i++;
            end
            drive_cdb();
        end
    endtask

    task automatic drain();
        while (live_cnt != 0) begin
            idle_cycle();
        end
    endtask

    task automatic run_segment(input string name, input int first, input int last);
        cur_test = name;
        apply_rows(first, last);
        drain();
    endtask

    // everything in flight is gone after a flush
    task automatic discard_pending();
        for (int i = 0; i < NUM_IDS; i++) begin
            pending[i] = 1'b0;
        end
        live_cnt = 0;
        mul_order.delete();
        div_order.delete();
        ev_due.delete();
        ev_tag.delete();
        ev_data.delete();
        ev_rob.delete();
    endtask

    // ----------------------------
    // result monitor
    // ----------------------------
    // results sampled at the falling edge
    always @(negedge clk) begin
        rob_id_t r;
        rob_id_t exp_rob;
        r = result_rob_id_o;
        if (rst_n_i && !flush_i) begin
            if (held && !result_valid_o) begin
                report_failure("result valid dropped before its transfer");
            end
            // a divider result may overtake a held multiplier result
            if (held && !(is_div[r] && !is_div[held_rob])) begin
                check_rob_id({cur_test, "_hold"}, held_rob, r);
                check_word({cur_test, "_hold"}, held_data, result_data_o);
            end
            if (result_valid_o && result_ready_i) begin
                exp_rob = is_div[r] ? div_order[0] : mul_order[0];
                check_rob_id(cur_test, exp_rob, r);
                check_word(cur_test, exp_data[r], result_data_o);
                if (outstanding[r] != 0) begin
                    report_failure($sformatf("%s: rob id %0d finished before its operands arrived",
                                             cur_test, r));
                end
                pending[r] = 1'b0;
                if (is_div[r]) begin
                    void'(div_order.pop_front());
                end else begin
                    void'(mul_order.pop_front());
                end
                retired_cnt++;
                live_cnt--;
            end
        end
        held      = rst_n_i && !flush_i && result_valid_o && !result_ready_i;
        held_rob  = r;
        held_data = result_data_o;
    end

    initial begin
        rst_n_i          = 1'b0;
        flush_i          = 1'b0;
        disp_valid_i     = 1'b0;
        disp_op_i        = OP_MUL;
        disp_rob_id_i    = '0;
        disp_src_a_i     = '0;
        disp_src_b_i     = '0;
        disp_tag_a_i     = '0;
        disp_tag_b_i     = '0;
        disp_present_a_i = 1'b0;
        disp_present_b_i = 1'b0;
        cdb_valid_i      = 1'b0;
        cdb_tag_i        = '0;
        cdb_data_i       = '0;
        result_ready_i   = 1'b0;
        for (int i = 0; i < NUM_IDS; i++) begin
            pending[i]     = 1'b0;
            is_div[i]      = 1'b0;
            outstanding[i] = 0;
        end
        repeat (5) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        check_flag("reset_disp_ready", 1'b1, disp_ready_o);
        check_flag("reset_result_valid", 1'b0, result_valid_o);

        run_segment("mul_ops", 0, 4);
        run_segment("div_ops", 5, 12);
        run_segment("late_operands", 13, 16);

        // head blocked on a late operand fills the queue
        cur_test = "queue_full";
        apply_rows(17, 20);
        idle_cycle();
        check_flag(cur_test, 1'b0, disp_ready_o);
        while (!disp_ready_o) begin
            idle_cycle();
        end
        drain();

        cur_test = "flush";
        apply_rows(FLUSH_FIRST, FLUSH_LAST);
        repeat (4) idle_cycle();
        next_cycle();
        flush_i        = 1'b1;
        result_ready_i = 1'b0;
        discard_pending();
        next_cycle();
        check_flag("flush_disp_ready", 1'b1, disp_ready_o);
        check_flag("flush_result_valid", 1'b0, result_valid_o);
        run_segment("after_flush", 24, 25);

        check_count("retired_results", NUM_ROWS - (FLUSH_LAST - FLUSH_FIRST + 1), retired_cnt);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/mdu_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_div_unit (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    mdu_req_if.unit   req,
    mdu_res_if.unit   res
);
    import mdu_pkg::*;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_PREP,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

    div_state_t           state_q;
    logic [DIV_CNT_W-1:0] step_q;

    mdu_op_t     op_q;
    rob_id_t     rob_id_q;
    word_t       a_q;
    word_t       b_q;
    word_t       dvsr_q;
    word_t       quo_q;
    word_t       rem_q;

    logic        is_signed;
    logic        is_rem;
    logic        neg_a;
    logic        neg_b;
    logic [32:0] rem_shift;
    logic [32:0] diff;
    word_t       quo_res;
    word_t       rem_res;

    assign is_signed = (op_q == OP_DIV) || (op_q == OP_MOD);
    assign is_rem    = (op_q == OP_MOD) || (op_q == OP_MODU);
    assign neg_a     = is_signed && a_q[31];
    assign neg_b     = is_signed && b_q[31];

    // one restoring step, a clear top bit means the subtract fits
    assign rem_shift = {rem_q, quo_q[31]};
    assign diff      = rem_shift - {1'b0, dvsr_q};

    // ----------------------------
    // control
    // ----------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            state_q <= DIV_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: if (req.valid) state_q <= DIV_PREP;
                DIV_PREP: begin
                    step_q  <= '0;
                    state_q <= DIV_RUN;
                end
                DIV_RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == DIV_CNT_W'(DIV_STEPS - 1)) state_q <= DIV_DONE;
                end
                DIV_DONE: if (res.ready) state_q <= DIV_IDLE;
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && req.valid) begin
            op_q     <= req.op;
            rob_id_q <= req.rob_id;
            a_q      <= req.src_a;
            b_q      <= req.src_b;
        end else if (state_q == DIV_PREP) begin
            // work on magnitudes, signs restored at the end
            quo_q  <= neg_a ? -a_q : a_q;
            dvsr_q <= neg_b ? -b_q : b_q;
            rem_q  <= '0;
        end else if (state_q == DIV_RUN) begin
            rem_q <= diff[32] ? rem_shift[31:0] : diff[31:0];
            quo_q <= {quo_q[30:0], ~diff[32]};
        end
    end

    // sign fixup and special cases
    always_comb begin
        quo_res = (neg_a ^ neg_b) ? -quo_q : quo_q;
        rem_res = neg_a ? -rem_q : rem_q;
        if (b_q == '0) begin
            quo_res = '1;
            rem_res = a_q;
        end else if (is_signed && (a_q == 32'h8000_0000) && (b_q == '1)) begin
            quo_res = a_q;
            rem_res = '0;
        end
    end

    assign req.ready  = (state_q == DIV_IDLE);
    assign res.valid  = (state_q == DIV_DONE);
    assign res.data   = is_rem ? rem_res : quo_res;
    assign res.rob_id = rob_id_q;

endmodule

`default_nettype wire

// File: rtl/mdu_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_issue_queue (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              flush_i,

    input  logic              disp_valid_i,
    output logic              disp_ready_o,
    input  mdu_pkg::mdu_op_t  disp_op_i,
    input  mdu_pkg::rob_id_t  disp_rob_id_i,
    input  mdu_pkg::word_t    disp_src_a_i,
    input  mdu_pkg::word_t    disp_src_b_i,
    input  mdu_pkg::rob_id_t  disp_tag_a_i,
    input  mdu_pkg::rob_id_t  disp_tag_b_i,
    input  logic              disp_present_a_i,
    input  logic              disp_present_b_i,

    input  logic              cdb_valid_i,
    input  mdu_pkg::rob_id_t  cdb_tag_i,
    input  mdu_pkg::word_t    cdb_data_i,

    mdu_req_if.issuer         mul_req,
    mdu_req_if.issuer         div_req
);
    import mdu_pkg::*;

    // per-entry storage
    mdu_op_t op_q     [IQ_DEPTH];
    rob_id_t rob_id_q [IQ_DEPTH];
    word_t   src_a_q  [IQ_DEPTH];
    word_t   src_b_q  [IQ_DEPTH];
    rob_id_t tag_a_q  [IQ_DEPTH];
    rob_id_t tag_b_q  [IQ_DEPTH];
    logic    rdy_a_q  [IQ_DEPTH];
    logic    rdy_b_q  [IQ_DEPTH];

    iq_ptr_t             head_q;
    iq_ptr_t             tail_q;
    logic [IQ_CNT_W-1:0] count_q;

    logic  disp_fire;
    logic  issue_fire;
    logic  head_valid;
    logic  head_is_div;
    logic  disp_rdy_a;
    logic  disp_rdy_b;
    word_t disp_val_a;
    word_t disp_val_b;

    assign disp_ready_o = (count_q < IQ_CNT_W'(IQ_DEPTH));
    assign disp_fire    = disp_valid_i && disp_ready_o;

    // operand capture for the entry being dispatched, cdb hit included
    always_comb begin
        disp_rdy_a = disp_present_a_i;
        disp_val_a = disp_src_a_i;
        disp_rdy_b = disp_present_b_i;
        disp_val_b = disp_src_b_i;
        if (!disp_present_a_i && cdb_valid_i && (cdb_tag_i == disp_tag_a_i)) begin
            disp_rdy_a = 1'b1;
            disp_val_a = cdb_data_i;
        end
        if (!disp_present_b_i && cdb_valid_i && (cdb_tag_i == disp_tag_b_i)) begin
            disp_rdy_b = 1'b1;
            disp_val_b = cdb_data_i;
        end
    end

    // ----------------------------
    // entry write and wakeup
    // ----------------------------
    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (disp_fire && (tail_q == iq_ptr_t'(i))) begin
                op_q[i]     <= disp_op_i;
                rob_id_q[i] <= disp_rob_id_i;
                tag_a_q[i]  <= disp_tag_a_i;
                tag_b_q[i]  <= disp_tag_b_i;
                src_a_q[i]  <= disp_val_a;
                src_b_q[i]  <= disp_val_b;
                rdy_a_q[i]  <= disp_rdy_a;
                rdy_b_q[i]  <= disp_rdy_b;
            end else begin
                // waiting operands snoop the cdb
                if (!rdy_a_q[i] && cdb_valid_i && (cdb_tag_i == tag_a_q[i])) begin
                    rdy_a_q[i] <= 1'b1;
                    src_a_q[i] <= cdb_data_i;
                end
                if (!rdy_b_q[i] && cdb_valid_i && (cdb_tag_i == tag_b_q[i])) begin
                    rdy_b_q[i] <= 1'b1;
                    src_b_q[i] <= cdb_data_i;
                end
            end
        end
    end

    // ----------------------------
    // head issue
    // ----------------------------
    assign head_valid  = (count_q != '0) && rdy_a_q[head_q] && rdy_b_q[head_q];
    assign head_is_div = op_q[head_q][OP_W-1];

    assign mul_req.valid  = head_valid && !head_is_div;
    assign mul_req.op     = op_q[head_q];
    assign mul_req.src_a  = src_a_q[head_q];
    assign mul_req.src_b  = src_b_q[head_q];
    assign mul_req.rob_id = rob_id_q[head_q];

    assign div_req.valid  = head_valid && head_is_div;
    assign div_req.op     = op_q[head_q];
    assign div_req.src_a  = src_a_q[head_q];
    assign div_req.src_b  = src_b_q[head_q];
    assign div_req.rob_id = rob_id_q[head_q];

    assign issue_fire = (mul_req.valid && mul_req.ready) || (div_req.valid && div_req.ready);

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (disp_fire) begin
                tail_q <= tail_q + 1'b1;
            end
            if (issue_fire) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + IQ_CNT_W'(disp_fire) - IQ_CNT_W'(issue_fire);
        end
    end

endmodule

`default_nettype wire

// File: rtl/mdu_mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_mul_unit (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    mdu_req_if.unit   req,
    mdu_res_if.unit   res
);
    import mdu_pkg::*;

    logic               s1_valid_q;
    logic signed [32:0] s1_a_q;
    logic signed [32:0] s1_b_q;
    mdu_op_t            s1_op_q;
    rob_id_t            s1_rob_id_q;

    logic               s2_valid_q;
    word_t              s2_data_q;
    rob_id_t            s2_rob_id_q;

    logic               s1_free;
    logic               s2_free;
    logic               ext_sign;
    logic signed [65:0] prod_wide;
    logic [63:0]        product;

    // a stage may load when empty or when it drains this cycle
    assign s2_free   = !s2_valid_q || res.ready;
    assign s1_free   = !s1_valid_q || s2_free;
    assign req.ready = s1_free;

    // mulhu is the only zero-extended op
    assign ext_sign  = (req.op == OP_MUL) || (req.op == OP_MULH);

    assign prod_wide = s1_a_q * s1_b_q;
    assign product   = prod_wide[63:0];

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (s2_free) begin
                s2_valid_q <= s1_valid_q;
            end
            if (s1_free) begin
                s1_valid_q <= req.valid;
            end
        end
    end

    // ----------------------------
    // pipeline payload
    // ----------------------------
    always_ff @(posedge clk) begin
        if (s1_free && req.valid) begin
            s1_a_q      <= {ext_sign & req.src_a[31], req.src_a};
            s1_b_q      <= {ext_sign & req.src_b[31], req.src_b};
            s1_op_q     <= req.op;
            s1_rob_id_q <= req.rob_id;
        end
        if (s2_free && s1_valid_q) begin
            s2_data_q   <= (s1_op_q == OP_MUL) ? product[31:0] : product[63:32];
            s2_rob_id_q <= s1_rob_id_q;
        end
    end

    assign res.valid  = s2_valid_q;
    assign res.data   = s2_data_q;
    assign res.rob_id = s2_rob_id_q;

endmodule

`default_nettype wire

// File: rtl/mdu_pkg.sv
`default_nettype none

package mdu_pkg;

    // ----------------------------
    // widths
    // ----------------------------
    localparam int WORD_W   = 32;
    localparam int ROB_ID_W = 5;
    localparam int OP_W     = 3;

    // queue sizing
    localparam int IQ_DEPTH = 4;
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
    // count must reach IQ_DEPTH itself
    localparam int IQ_CNT_W = $clog2(IQ_DEPTH + 1);

    // divider iteration count
    localparam int DIV_STEPS = 32;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    // ----------------------------
    // types
    // ----------------------------
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [ROB_ID_W-1:0] rob_id_t;
    typedef logic [OP_W-1:0]     mdu_op_t;
    typedef logic [IQ_PTR_W-1:0] iq_ptr_t;

    // ----------------------------
    // op codes
    // ----------------------------
    // multiplier ops, top bit clear
    localparam mdu_op_t OP_MUL   = 3'b000;
    localparam mdu_op_t OP_MULH  = 3'b001;
    localparam mdu_op_t OP_MULHU = 3'b010;

    // divider ops, top bit set
    localparam mdu_op_t OP_DIV   = 3'b100;
    localparam mdu_op_t OP_DIVU  = 3'b101;
    localparam mdu_op_t OP_MOD   = 3'b110;
    localparam mdu_op_t OP_MODU  = 3'b111;

endpackage

`default_nettype wire

// File: rtl/mdu_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mdu_req_if;
    import mdu_pkg::*;

    logic    valid;
    logic    ready;
    mdu_op_t op;
    word_t   src_a;
    word_t   src_b;
    rob_id_t rob_id;

    // issue queue side
    modport issuer (output valid, output op, output src_a, output src_b,
                    output rob_id, input ready);

    // execution unit side
    modport unit (input valid, input op, input src_a, input src_b,
                  input rob_id, output ready);

endinterface

`default_nettype wire

// File: rtl/mdu_res_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mdu_res_if;
    import mdu_pkg::*;

    logic    valid;
    logic    ready;
    word_t   data;
    rob_id_t rob_id;

    // execution unit side
    modport unit (output valid, output data, output rob_id, input ready);

    // result arbiter side
    modport merger (input valid, input data, input rob_id, output ready);

endinterface

`default_nettype wire

// File: rtl/mdu_result_arb.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_result_arb (
    mdu_res_if.merger         mul_res,
    mdu_res_if.merger         div_res,

    output logic              result_valid_o,
    input  logic              result_ready_i,
    output mdu_pkg::word_t    result_data_o,
    output mdu_pkg::rob_id_t  result_rob_id_o
);

    logic sel_div;

    // ----------------------------
    // fixed priority, divider first
    // ----------------------------
    // the divider holds its single op until taken, so it
    // wins whenever it has a result
    assign sel_div = div_res.valid;

    assign result_valid_o  = div_res.valid || mul_res.valid;
    assign result_data_o   = sel_div ? div_res.data : mul_res.data;
    assign result_rob_id_o = sel_div ? div_res.rob_id : mul_res.rob_id;

    // only the selected source sees ready
    assign div_res.ready = result_ready_i;
    assign mul_res.ready = result_ready_i && !sel_div;

endmodule

`default_nettype wire

// File: rtl/mdu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_top (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              flush_i,

    // dispatch
    input  logic              disp_valid_i,
    output logic              disp_ready_o,
    input  mdu_pkg::mdu_op_t  disp_op_i,
    input  mdu_pkg::rob_id_t  disp_rob_id_i,
    input  mdu_pkg::word_t    disp_src_a_i,
    input  mdu_pkg::word_t    disp_src_b_i,
    input  mdu_pkg::rob_id_t  disp_tag_a_i,
    input  mdu_pkg::rob_id_t  disp_tag_b_i,
    input  logic              disp_present_a_i,
    input  logic              disp_present_b_i,

    // common data bus
    input  logic              cdb_valid_i,
    input  mdu_pkg::rob_id_t  cdb_tag_i,
    input  mdu_pkg::word_t    cdb_data_i,

    // merged result
    output logic              result_valid_o,
    input  logic              result_ready_i,
    output mdu_pkg::word_t    result_data_o,
    output mdu_pkg::rob_id_t  result_rob_id_o
);

    mdu_req_if mul_req ();
    mdu_req_if div_req ();
    mdu_res_if mul_res ();
    mdu_res_if div_res ();

    mdu_issue_queue i_issue_queue (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .disp_valid_i     (disp_valid_i),
        .disp_ready_o     (disp_ready_o),
        .disp_op_i        (disp_op_i),
        .disp_rob_id_i    (disp_rob_id_i),
        .disp_src_a_i     (disp_src_a_i),
        .disp_src_b_i     (disp_src_b_i),
        .disp_tag_a_i     (disp_tag_a_i),
        .disp_tag_b_i     (disp_tag_b_i),
        .disp_present_a_i (disp_present_a_i),
        .disp_present_b_i (disp_present_b_i),
        .cdb_valid_i      (cdb_valid_i),
        .cdb_tag_i        (cdb_tag_i),
        .cdb_data_i       (cdb_data_i),
        .mul_req          (mul_req.issuer),
        .div_req          (div_req.issuer)
    );

    mdu_mul_unit i_mul_unit (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .req     (mul_req.unit),
        .res     (mul_res.unit)
    );

    mdu_div_unit i_div_unit (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .req     (div_req.unit),
        .res     (div_res.unit)
    );

    mdu_result_arb i_result_arb (
        .mul_res         (mul_res.merger),
        .div_res         (div_res.merger),
        .result_valid_o  (result_valid_o),
        .result_ready_i  (result_ready_i),
        .result_data_o   (result_data_o),
        .result_rob_id_o (result_rob_id_o)
    );

endmodule

`default_nettype wire

// File: vlog.f
rtl/mdu_pkg.sv
rtl/mdu_req_if.sv
rtl/mdu_res_if.sv
rtl/mdu_issue_queue.sv
rtl/mdu_mul_unit.sv
rtl/mdu_div_unit.sv
rtl/mdu_result_arb.sv
rtl/mdu_top.sv
dv/mdu_tb.sv
